// ==== sd_ctrl.f ====
src/sd_cmd_pkg.sv
src/sd_card_pkg.sv
src/sd_clk_gen.sv
src/sd_crc7.sv
src/sd_cmd_engine.sv
src/sd_init_seq.sv
src/sd_ctrl.sv
test/sd_card_model.sv
test/tb_sd_ctrl.sv

// ==== Makefile ====
TOP := tb_sd_ctrl

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sd_ctrl.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sd_ctrl.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

// ==== test/tb_sd_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the SD host command path
// Runs card identification against a card model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_sd_ctrl;

    typedef struct packed {
        sd_cmd_pkg::cmd_idx_t idx;
        sd_cmd_pkg::cmd_arg_t arg;
    } cmd_exp_t;

    localparam int SCLK_HALF  = 4;
    localparam int SCENARIOS  = 4;
    localparam int MAX_CMDS   = 12;
    localparam int CMD_CLOCKS = 48 + 64 + 136;
    // All scenarios in card clocks, doubled for margin, in ns
    localparam int WATCHDOG_NS = 2 * SCENARIOS * (MAX_CMDS * CMD_CLOCKS + 74) *
                                 2 * SCLK_HALF * 8;

    logic                  clk;
    logic                  nrst;
    logic                  card_cmd;
    logic                  sclk;
    logic                  host_cmd;
    logic                  host_dir;
    sd_card_pkg::sd_type_e sd_type;
    sd_card_pkg::rca_t     rca;
    logic                  init_done;
    logic                  init_err;
    logic                  answer_cmd8;
    logic                  card_hcs;
    logic [1:0]            busy_cnt;
    sd_card_pkg::rca_t     card_rca;
    logic                  bad_crc;
    logic [47:0]           frame;
    logic                  frame_stb;
    cmd_exp_t              exp_q[$];
    string                 test_name;
    int                    frame_no;
    int                    pre_rises;
    int                    value_errs = 0;
    int                    other_errs = 0;

    sd_ctrl UUT (
        .i_clk       (clk),
        .i_nrst      (nrst),
        .i_cmd       (card_cmd),
        .o_sclk      (sclk),
        .o_cmd       (host_cmd),
        .o_cmd_dir   (host_dir),
        .o_sd_type   (sd_type),
        .o_rca       (rca),
        .o_init_done (init_done),
        .o_init_err  (init_err)
    );

    sd_card_model card (
        .i_clk         (clk),
        .i_sclk        (sclk),
        .i_cmd         (host_cmd),
        .i_cmd_dir     (host_dir),
        .i_answer_cmd8 (answer_cmd8),
        .i_hcs         (card_hcs),
        .i_busy_cnt    (busy_cnt),
        .i_rca         (card_rca),
        .i_bad_crc     (bad_crc),
        .o_cmd         (card_cmd),
        .o_frame       (frame),
        .o_frame_stb   (frame_stb)
    );

    // Long division by 0x89 over the message times x^7
    function automatic sd_cmd_pkg::crc7_t crc7_ref(input logic [39:0] d);
        logic [46:0] r;
        r = {d, 7'd0};
        for (int i = 46; i >= 7; i--) begin
            if (r[i]) begin
                r[i -: 8] ^= 8'h89;
            end
        end
        return r[6:0];
    endfunction

    task automatic note_failure(input string msg);
        $display("%s", msg);
        other_errs++;
    endtask

    task automatic check_cmd(input string name, input sd_cmd_pkg::cmd_idx_t exp_idx,
                             input sd_cmd_pkg::cmd_arg_t exp_arg,
                             input sd_cmd_pkg::cmd_idx_t act_idx,
                             input sd_cmd_pkg::cmd_arg_t act_arg);
        if (act_idx !== exp_idx || act_arg !== exp_arg) begin
            $display("Fail %s: expected CMD%0d arg 0x%08h, actual CMD%0d arg 0x%08h",
                     name, exp_idx, exp_arg, act_idx, act_arg);
            value_errs++;
        end
    endtask

    task automatic check_type(input string name, input sd_card_pkg::sd_type_e exp_t,
                              input sd_card_pkg::sd_type_e act_t);
        if (act_t !== exp_t) begin
            $display("Fail %s: expected type %s, actual %s", name, exp_t.name(), act_t.name());
            value_errs++;
        end
    endtask

    task automatic check_rca(input string name, input sd_card_pkg::rca_t exp_r,
                             input sd_card_pkg::rca_t act_r);
        if (act_r !== exp_r) begin
            $display("Fail %s: expected RCA 0x%04h, actual 0x%04h", name, exp_r, act_r);
            value_errs++;
        end
    endtask

    task automatic check_crc(input string name, input sd_cmd_pkg::crc7_t exp_c,
                             input sd_cmd_pkg::crc7_t act_c);
        if (act_c !== exp_c) begin
            $display("Fail %s: expected CRC7 0x%02h, actual 0x%02h", name, exp_c, act_c);
            value_errs++;
        end
    endtask

    task automatic run_scenario(input string name, input logic answer, input logic hcs,
                                input logic corrupt);
        int                    busy;
        sd_card_pkg::rca_t     r;
        sd_card_pkg::sd_type_e want_type;
        busy      = int'($urandom % 4);
        r         = 16'($urandom);
        test_name = name;
        frame_no  = 0;
        exp_q.delete();
        exp_q.push_back(cmd_exp_t'{sd_cmd_pkg::CMD0, 32'h0});
        exp_q.push_back(cmd_exp_t'{sd_cmd_pkg::CMD8, 32'h0000_01AA});
        // One CMD55/ACMD41 pair per busy reply plus the ready one
        repeat (busy + 1) begin
            exp_q.push_back(cmd_exp_t'{sd_cmd_pkg::CMD55, 32'h0});
            exp_q.push_back(cmd_exp_t'{sd_cmd_pkg::ACMD41, {1'b0, answer, 6'd0, 24'hFF8000}});
        end
        exp_q.push_back(cmd_exp_t'{sd_cmd_pkg::CMD2, 32'h0});
        exp_q.push_back(cmd_exp_t'{sd_cmd_pkg::CMD3, 32'h0});
        if (corrupt) begin
            want_type = sd_card_pkg::SDCARD_UNUSABLE;
        end else if (!answer) begin
            want_type = sd_card_pkg::SDCARD_VER1X;
        end else if (hcs) begin
            want_type = sd_card_pkg::SDCARD_VER2X_HC;
        end else begin
            want_type = sd_card_pkg::SDCARD_VER2X_SC;
        end

        @(negedge clk);
        nrst        = 1'b0;
        answer_cmd8 = answer;
        card_hcs    = hcs;
        busy_cnt    = 2'(busy);
        card_rca    = r;
        bad_crc     = corrupt;
        repeat (10) @(negedge clk);
        if (host_cmd !== 1'b1 || host_dir !== 1'b0 || init_done !== 1'b0 ||
            init_err !== 1'b0) begin
            note_failure({name, ": command line or status flags wrong during reset"});
        end
        check_type({name, " reset"}, sd_card_pkg::SDCARD_UNKNOWN, sd_type);
        check_rca({name, " reset"}, '0, rca);
        nrst = 1'b1;

        wait (init_done || init_err);
        @(negedge clk);
        if (init_done !== !corrupt || init_err !== corrupt) begin
            note_failure($sformatf("%s: finished with done=%b err=%b, the wrong outcome",
                                   name, init_done, init_err));
        end
        check_type(name, want_type, sd_type);
        if (!corrupt) begin
            check_rca(name, r, rca);
        end
        if (exp_q.size() != 0) begin
            note_failure($sformatf("%s: %0d expected command frames never arrived",
                                   name, exp_q.size()));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Compares each host frame with the next expected command
    initial begin
        cmd_exp_t want;
        string    name;
        forever begin
            @(posedge frame_stb);
            @(posedge clk);
            frame_no++;
            name = $sformatf("%s frame %0d", test_name, frame_no);
            if (frame[47:46] !== 2'b01 || frame[0] !== 1'b1) begin
                note_failure({name, ": start, transmission or stop bit is wrong"});
            end
            check_crc(name, crc7_ref(frame[47:8]), frame[7:1]);
            if (exp_q.size() == 0) begin
                note_failure({name, ": command frame arrived after the sequence ended"});
            end else begin
                want = exp_q.pop_front();
                check_cmd(name, want.idx, want.arg, frame[45:40], frame[39:8]);
            end
        end
    end

    // Power-up clocks with the line high, up to the first start bit
    initial begin
        forever begin
            @(posedge nrst);
            pre_rises = 0;
            @(posedge sclk);
            while (host_cmd) begin
                pre_rises++;
                @(posedge sclk);
            end
            if (pre_rises < 74) begin
                note_failure($sformatf("%s: only %0d card clocks before the first start bit",
                                       test_name, pre_rises));
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, identification did not finish", WATCHDOG_NS);
        $display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs + 1);
        $display("Verification failed");
        $finish;
    end

    initial begin
        void'($urandom(41470));
        nrst        = 1'b0;
        answer_cmd8 = 1'b1;
        card_hcs    = 1'b1;
        busy_cnt    = '0;
        card_rca    = '0;
        bad_crc     = 1'b0;
        run_scenario("ver2_hc", 1'b1, 1'b1, 1'b0);
        run_scenario("ver2_sc", 1'b1, 1'b0, 1'b0);
        run_scenario("ver1", 1'b0, 1'b0, 1'b0);
        run_scenario("bad_r6_crc", 1'b1, 1'b1, 1'b1);
        $display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== test/sd_card_model.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Behavioral SD card for the identification sequence
// Decodes host frames and answers per scenario
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sd_card_model (
    input  logic              i_clk,
    input  logic              i_sclk,
    input  logic              i_cmd,
    input  logic              i_cmd_dir,
    input  logic              i_answer_cmd8,
    input  logic              i_hcs,
    input  logic [1:0]        i_busy_cnt,
    input  sd_card_pkg::rca_t i_rca,
    input  logic              i_bad_crc,
    output logic              o_cmd,
    output logic [47:0]       o_frame,
    output logic              o_frame_stb
);

    logic [47:0]  frame;
    logic [127:0] cid;
    int           busy_left;
    logic         ready;

    // Galois form of x^7 + x^3 + 1
    function automatic logic [6:0] resp_crc(input logic [39:0] d);
        logic [6:0] c;
        logic       fb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = d[i] ^ c[6];
            c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    // MSB first, each bit set up after a falling card clock
    task automatic send_resp(input logic [135:0] bits, input int len);
        // Two idle clocks before the start bit
        repeat (2) @(negedge i_sclk);
        for (int k = len - 1; k >= 0; k--) begin
            @(negedge i_sclk);
            @(negedge i_clk);
            o_cmd = bits[k];
        end
    endtask

    task automatic send_short(input logic [5:0] idx, input logic [31:0] data,
                              input logic corrupt);
        logic [6:0] crc;
        crc = resp_crc({2'b00, idx, data});
        if (corrupt) begin
            crc = crc ^ 7'h01;
        end
        send_resp(136'({2'b00, idx, data, crc, 1'b1}), 48);
    endtask

    initial begin
        o_cmd       = 1'b1;
        o_frame     = '0;
        o_frame_stb = 1'b0;
        busy_left   = 0;
        cid         = {8{16'hC35A}};
        forever begin
            @(posedge i_sclk);
            if (!i_cmd_dir && !i_cmd) begin
                frame[47] = 1'b0;
                for (int k = 46; k >= 0; k--) begin
                    @(posedge i_sclk);
                    frame[k] = i_cmd;
                end
                @(negedge i_clk);
                o_frame     = frame;
                o_frame_stb = 1'b1;
                @(negedge i_clk);
                o_frame_stb = 1'b0;
                case (frame[45:40])
                    // CMD0 restarts the busy countdown
                    6'd0: busy_left = int'(i_busy_cnt);
                    6'd8: begin
                        if (i_answer_cmd8) begin
                            send_short(6'd8, {20'd0, frame[19:8]}, 1'b0);
                        end
                    end
                    6'd55: send_short(6'd55, 32'h0000_0120, 1'b0);
                    6'd41: begin
                        ready = (busy_left == 0);
                        if (!ready) begin
                            busy_left--;
                        end
                        // R3 carries the OCR with all-ones index and CRC fields
                        send_resp(136'({2'b00, 6'h3F, ready, ready & i_hcs & frame[38],
                                        6'd0, 24'hFF8000, 7'h7F, 1'b1}), 48);
                    end
                    6'd2: send_resp({2'b00, 6'h3F, cid[127:1], 1'b1}, 136);
                    6'd3: send_short(6'd3, {i_rca, 16'h0500}, i_bad_crc);
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

// ==== src/sd_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SD host controller command path, top level
// Runs card identification in SD bus mode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sd_ctrl #(
    parameter int SCLK_HALF    = 4,
    parameter int RESP_TIMEOUT = 64
) (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  logic                  i_cmd,
    output logic                  o_sclk,
    output logic                  o_cmd,
    output logic                  o_cmd_dir,
    output sd_card_pkg::sd_type_e o_sd_type,
    output sd_card_pkg::rca_t     o_rca,
    output logic                  o_init_done,
    output logic                  o_init_err
);

    logic                  sclk_rise;
    logic                  sclk_fall;
    logic                  req;
    logic                  ack;
    sd_cmd_pkg::cmd_req_t  cmd_req;
    sd_cmd_pkg::cmd_resp_t cmd_resp;

    sd_clk_gen #(
        .SCLK_HALF (SCLK_HALF)
    ) u_clk_gen (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .o_sclk      (o_sclk),
        .o_sclk_rise (sclk_rise),
        .o_sclk_fall (sclk_fall)
    );

    sd_init_seq u_init_seq (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_sclk_rise (sclk_rise),
        .o_req       (req),
        .o_cmd_req   (cmd_req),
        .i_ack       (ack),
        .i_cmd_resp  (cmd_resp),
        .o_sd_type   (o_sd_type),
        .o_rca       (o_rca),
        .o_init_done (o_init_done),
        .o_init_err  (o_init_err)
    );

    sd_cmd_engine #(
        .RESP_TIMEOUT (RESP_TIMEOUT)
    ) u_cmd_engine (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_sclk_rise (sclk_rise),
        .i_sclk_fall (sclk_fall),
        .i_req       (req),
        .i_cmd_req   (cmd_req),
        .o_ack       (ack),
        .o_cmd_resp  (cmd_resp),
        .i_cmd       (i_cmd),
        .o_cmd       (o_cmd),
        .o_cmd_dir   (o_cmd_dir)
    );

endmodule

// ==== src/sd_init_seq.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SD card identification sequencer
// Power-up delay, then CMD0, CMD8, CMD55/ACMD41,
// CMD2 and CMD3 with card type and RCA tracking
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sd_init_seq (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  logic                  i_sclk_rise,
    output logic                  o_req,
    output sd_cmd_pkg::cmd_req_t  o_cmd_req,
    input  logic                  i_ack,
    input  sd_cmd_pkg::cmd_resp_t i_cmd_resp,
    output sd_card_pkg::sd_type_e o_sd_type,
    output sd_card_pkg::rca_t     o_rca,
    output logic                  o_init_done,
    output logic                  o_init_err
);

    localparam int PRE_W = $clog2(sd_card_pkg::PREINIT_CLOCKS + 1);

    sd_card_pkg::init_state_e state_q;
    logic [PRE_W-1:0]         pre_cnt;
    logic                     hcs_q;
    logic                     issue;

    // Request built for each issue state
    function automatic sd_cmd_pkg::cmd_req_t make_req(input sd_card_pkg::init_state_e st,
                                                      input logic hcs);
        sd_cmd_pkg::cmd_req_t r;
        r = '{idx: sd_cmd_pkg::CMD0, arg: '0, resp: sd_cmd_pkg::RESP_NONE};
        case (st)
            sd_card_pkg::INIT_CMD8: begin
                r.idx  = sd_cmd_pkg::CMD8;
                r.arg  = {20'h0, sd_card_pkg::CMD8_VHS, sd_card_pkg::CMD8_PATTERN};
                r.resp = sd_cmd_pkg::RESP_R7;
            end
            sd_card_pkg::INIT_CMD55: begin
                r.idx  = sd_cmd_pkg::CMD55;
                r.resp = sd_cmd_pkg::RESP_R1;
            end
            sd_card_pkg::INIT_ACMD41: begin
                r.idx  = sd_cmd_pkg::ACMD41;
                r.arg  = {1'b0, hcs, 6'd0, sd_card_pkg::OCR_WINDOW};
                r.resp = sd_cmd_pkg::RESP_R3;
            end
            sd_card_pkg::INIT_CMD2: begin
                r.idx  = sd_cmd_pkg::CMD2;
                r.resp = sd_cmd_pkg::RESP_R2;
            end
            sd_card_pkg::INIT_CMD3: begin
                r.idx  = sd_cmd_pkg::CMD3;
                r.resp = sd_cmd_pkg::RESP_R6;
            end
            default: begin
            end
        endcase
        return r;
    endfunction

    // New command only once the previous ack has dropped
    assign issue = !i_ack && (state_q inside {sd_card_pkg::INIT_CMD0, sd_card_pkg::INIT_CMD8,
                                              sd_card_pkg::INIT_CMD55, sd_card_pkg::INIT_ACMD41,
                                              sd_card_pkg::INIT_CMD2, sd_card_pkg::INIT_CMD3});

    always_ff @(posedge i_clk) begin
        if (issue) begin
            o_cmd_req <= make_req(state_q, hcs_q);
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q     <= sd_card_pkg::INIT_PREINIT;
            pre_cnt     <= '0;
            hcs_q       <= 1'b1;
            o_req       <= 1'b0;
            o_sd_type   <= sd_card_pkg::SDCARD_UNKNOWN;
            o_rca       <= '0;
            o_init_done <= 1'b0;
            o_init_err  <= 1'b0;
        end else if (state_q == sd_card_pkg::INIT_PREINIT) begin
            if (pre_cnt == PRE_W'(sd_card_pkg::PREINIT_CLOCKS)) begin
                state_q <= sd_card_pkg::INIT_CMD0;
            end else if (i_sclk_rise) begin
                pre_cnt <= pre_cnt + 1'b1;
            end
        end else if (issue) begin
            o_req   <= 1'b1;
            state_q <= sd_card_pkg::INIT_WAIT_ACK;
        end else if (state_q == sd_card_pkg::INIT_WAIT_ACK && i_ack) begin
            o_req <= 1'b0;
            if (i_cmd_resp.err != sd_cmd_pkg::CMDERR_NONE) begin
                // A silent card at CMD8 is version 1.x, anything else is fatal
                if (o_cmd_req.idx == sd_cmd_pkg::CMD8 &&
                    i_cmd_resp.err == sd_cmd_pkg::CMDERR_NO_RESPONSE) begin
                    o_sd_type <= sd_card_pkg::SDCARD_VER1X;
                    hcs_q     <= 1'b0;
                    state_q   <= sd_card_pkg::INIT_CMD55;
                end else begin
                    o_sd_type  <= sd_card_pkg::SDCARD_UNUSABLE;
                    o_init_err <= 1'b1;
                    state_q    <= sd_card_pkg::INIT_ERROR;
                end
            end else begin
                case (o_cmd_req.idx)
                    sd_cmd_pkg::CMD0: state_q <= sd_card_pkg::INIT_CMD8;
                    sd_cmd_pkg::CMD8: begin
                        if (i_cmd_resp.data[11:0] ==
                            {sd_card_pkg::CMD8_VHS, sd_card_pkg::CMD8_PATTERN}) begin
                            state_q <= sd_card_pkg::INIT_CMD55;
                        end else begin
                            o_sd_type  <= sd_card_pkg::SDCARD_UNUSABLE;
                            o_init_err <= 1'b1;
                            state_q    <= sd_card_pkg::INIT_ERROR;
                        end
                    end
                    sd_cmd_pkg::CMD55: state_q <= sd_card_pkg::INIT_ACMD41;
                    sd_cmd_pkg::ACMD41: begin
                        // OCR bit 31 low means the card is still busy
                        if (!i_cmd_resp.data[31]) begin
                            state_q <= sd_card_pkg::INIT_CMD55;
                        end else begin
                            hcs_q <= i_cmd_resp.data[30];
                            if (i_cmd_resp.data[30]) begin
                                o_sd_type <= sd_card_pkg::SDCARD_VER2X_HC;
                            end else if (o_sd_type != sd_card_pkg::SDCARD_VER1X) begin
                                o_sd_type <= sd_card_pkg::SDCARD_VER2X_SC;
                            end
                            state_q <= sd_card_pkg::INIT_CMD2;
                        end
                    end
                    sd_cmd_pkg::CMD2: state_q <= sd_card_pkg::INIT_CMD3;
                    default: begin
                        o_rca       <= i_cmd_resp.data[31:16];
                        o_init_done <= 1'b1;
                        state_q     <= sd_card_pkg::INIT_DONE;
                    end
                endcase
            end
        end
    end

    assert property (@(posedge i_clk) disable iff (!i_nrst) !(o_init_done && o_init_err));

endmodule

// ==== src/sd_cmd_engine.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SD command line engine
// Sends one command frame with CRC7, receives and
// checks the response, answers with a 4-phase ack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sd_cmd_engine #(
    parameter int RESP_TIMEOUT = 64
) (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  logic                  i_sclk_rise,
    input  logic                  i_sclk_fall,
    input  logic                  i_req,
    input  sd_cmd_pkg::cmd_req_t  i_cmd_req,
    output logic                  o_ack,
    output sd_cmd_pkg::cmd_resp_t o_cmd_resp,
    input  logic                  i_cmd,
    output logic                  o_cmd,
    output logic                  o_cmd_dir
);

    typedef enum logic [2:0] {IDLE, SEND, WAIT_START, RECV, DONE} eng_state_e;

    localparam int TMO_W = $clog2(RESP_TIMEOUT + 1);

    eng_state_e           state_q;
    logic [7:0]           bit_cnt;
    logic [TMO_W-1:0]     tmo_cnt;
    sd_cmd_pkg::cmd_req_t req_q;
    logic [39:0]          tx_sh;
    logic [39:0]          rx_sh;
    logic [39:0]          rx_next;
    logic [7:0]           rx_last;
    logic                 tx_bit;
    logic                 checked;
    logic                 crc_clear;
    logic                 crc_shift;
    logic                 crc_bit;
    sd_cmd_pkg::crc7_t    crc;

    sd_crc7 u_crc7 (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (crc_clear),
        .i_shift (crc_shift),
        .i_bit   (crc_bit),
        .o_crc   (crc)
    );

    always_comb begin
        // Bit 40 is the first CRC bit, the rest follow from tx_sh
        tx_bit  = (bit_cnt == 8'd40) ? crc[6] : tx_sh[39];
        rx_next = {rx_sh[38:0], i_cmd};
        rx_last = (req_q.resp == sd_cmd_pkg::RESP_R2) ?
                  8'(sd_cmd_pkg::LONG_FRAME_BITS - 1) : 8'(sd_cmd_pkg::FRAME_BITS - 1);
        checked = (req_q.resp == sd_cmd_pkg::RESP_R1) ||
                  (req_q.resp == sd_cmd_pkg::RESP_R6) ||
                  (req_q.resp == sd_cmd_pkg::RESP_R7);
        // A cleared CRC equals one that has taken the 0 start bit
        crc_clear = (state_q == IDLE) || (state_q == WAIT_START);
        crc_shift = 1'b0;
        crc_bit   = 1'b0;
        if (state_q == SEND && i_sclk_fall && bit_cnt < 8'd40) begin
            crc_shift = 1'b1;
            crc_bit   = tx_sh[39];
        end else if (state_q == RECV && i_sclk_rise && bit_cnt < 8'd40) begin
            crc_shift = 1'b1;
            crc_bit   = i_cmd;
        end
    end

    // Control path
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q   <= IDLE;
            bit_cnt   <= '0;
            tmo_cnt   <= '0;
            o_ack     <= 1'b0;
            o_cmd     <= 1'b1;
            o_cmd_dir <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (i_req) begin
                        bit_cnt <= '0;
                        state_q <= SEND;
                    end
                end
                SEND: begin
                    if (i_sclk_fall) begin
                        if (bit_cnt == 8'(sd_cmd_pkg::FRAME_BITS)) begin
                            if (req_q.resp == sd_cmd_pkg::RESP_NONE) begin
                                o_ack   <= 1'b1;
                                state_q <= DONE;
                            end else begin
                                // Stop bit done, hand the line to the card
                                o_cmd_dir <= 1'b1;
                                tmo_cnt   <= '0;
                                state_q   <= WAIT_START;
                            end
                        end else begin
                            o_cmd   <= tx_bit;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                WAIT_START: begin
                    if (i_sclk_rise) begin
                        if (!i_cmd) begin
                            bit_cnt <= 8'd1;
                            state_q <= RECV;
                        end else if (tmo_cnt == TMO_W'(RESP_TIMEOUT - 1)) begin
                            o_ack     <= 1'b1;
                            o_cmd_dir <= 1'b0;
                            state_q   <= DONE;
                        end else begin
                            tmo_cnt <= tmo_cnt + 1'b1;
                        end
                    end
                end
                RECV: begin
                    if (i_sclk_rise) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == rx_last) begin
                            o_ack     <= 1'b1;
                            o_cmd_dir <= 1'b0;
                            state_q   <= DONE;
                        end
                    end
                end
                DONE: begin
                    if (!i_req) begin
                        o_ack   <= 1'b0;
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Frame and response data
    always_ff @(posedge i_clk) begin
        if (state_q == IDLE && i_req) begin
            req_q <= i_cmd_req;
            tx_sh <= {2'b01, i_cmd_req.idx, i_cmd_req.arg};
        end
        if (state_q == SEND && i_sclk_fall) begin
            if (bit_cnt == 8'd40) begin
                tx_sh <= {crc[5:0], 1'b1, 33'd0};
            end else begin
                tx_sh <= {tx_sh[38:0], 1'b0};
            end
            if (bit_cnt == 8'(sd_cmd_pkg::FRAME_BITS)) begin
                o_cmd_resp <= '{idx: req_q.idx, data: '0, err: sd_cmd_pkg::CMDERR_NONE};
            end
        end
        if (state_q == WAIT_START && i_sclk_rise) begin
            rx_sh <= rx_next;
            o_cmd_resp.err <= sd_cmd_pkg::CMDERR_NO_RESPONSE;
        end
        if (state_q == RECV && i_sclk_rise) begin
            rx_sh <= rx_next;
            if (bit_cnt == 8'd39) begin
                o_cmd_resp.idx  <= rx_next[37:32];
                o_cmd_resp.data <= rx_next[31:0];
            end
            // Received CRC sits in rx_sh[6:0] when the stop bit arrives
            if (!i_cmd) begin
                o_cmd_resp.err <= sd_cmd_pkg::CMDERR_BAD_FRAME;
            end else if (checked && rx_sh[6:0] != crc) begin
                o_cmd_resp.err <= sd_cmd_pkg::CMDERR_BAD_CRC;
            end else if (checked && o_cmd_resp.idx != req_q.idx) begin
                o_cmd_resp.err <= sd_cmd_pkg::CMDERR_BAD_FRAME;
            end else begin
                o_cmd_resp.err <= sd_cmd_pkg::CMDERR_NONE;
            end
        end
    end

    // Ack only answers a pending request
    assert property (@(posedge i_clk) disable iff (!i_nrst) $rose(o_ack) |-> i_req);

    assert property (@(posedge i_clk) disable iff (!i_nrst) (state_q == SEND) |-> !o_cmd_dir);

endmodule

// ==== src/sd_crc7.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial CRC7 for command frames
// Polynomial x^7 + x^3 + 1, zero initial value
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sd_crc7 (
    input  logic              i_clk,
    input  logic              i_nrst,
    input  logic              i_clear,
    input  logic              i_shift,
    input  logic              i_bit,
    output sd_cmd_pkg::crc7_t o_crc
);

    logic fb;

    assign fb = i_bit ^ o_crc[6];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_crc <= '0;
        end else if (i_clear) begin
            o_crc <= '0;
        end else if (i_shift) begin
            o_crc <= {o_crc[5:3], o_crc[2] ^ fb, o_crc[1:0], fb};
        end
    end

endmodule

// ==== src/sd_clk_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SD card clock divider
// Makes the card clock and its edge strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sd_clk_gen #(
    parameter int SCLK_HALF = 4
) (
    input  logic i_clk,
    input  logic i_nrst,
    output logic o_sclk,
    output logic o_sclk_rise,
    output logic o_sclk_fall
);

    localparam int CNT_W = (SCLK_HALF > 1) ? $clog2(SCLK_HALF) : 1;

    logic [CNT_W-1:0] cnt_q;
    logic             terminal;

    assign terminal = (cnt_q == CNT_W'(SCLK_HALF - 1));

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            cnt_q       <= '0;
            o_sclk      <= 1'b0;
            o_sclk_rise <= 1'b0;
            o_sclk_fall <= 1'b0;
        end else begin
            // Strobe is high in the cycle where the new level appears
            o_sclk_rise <= terminal && !o_sclk;
            o_sclk_fall <= terminal && o_sclk;
            if (terminal) begin
                cnt_q  <= '0;
                o_sclk <= ~o_sclk;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

endmodule

// ==== src/sd_card_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SD card state definitions
// Card type, sequencer states, RCA and fixed fields
// of the CMD8 and ACMD41 arguments
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package sd_card_pkg;

    typedef enum logic [2:0] {
        SDCARD_UNKNOWN,
        SDCARD_VER1X,
        SDCARD_VER2X_SC,
        SDCARD_VER2X_HC,
        SDCARD_UNUSABLE
    } sd_type_e;

    // Issue states send one command, INIT_WAIT_ACK parses the reply
    typedef enum logic [3:0] {
        INIT_PREINIT,
        INIT_CMD0,
        INIT_CMD8,
        INIT_CMD55,
        INIT_ACMD41,
        INIT_CMD2,
        INIT_CMD3,
        INIT_WAIT_ACK,
        INIT_DONE,
        INIT_ERROR
    } init_state_e;

    typedef logic [15:0] rca_t;

    // 2.7-3.6 V supply and the echo pattern of CMD8
    localparam logic [3:0]  CMD8_VHS     = 4'h1;
    localparam logic [7:0]  CMD8_PATTERN = 8'hAA;
    localparam logic [23:0] OCR_WINDOW   = 24'hFF8000;

    // Power-up clocks with the command line held high
    localparam int PREINIT_CLOCKS = 74;

endpackage

// ==== src/sd_cmd_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SD command protocol definitions
// Command indices, response kinds, result codes and
// the request/response records of the command path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package sd_cmd_pkg;

    typedef logic [5:0]  cmd_idx_t;
    typedef logic [31:0] cmd_arg_t;
    typedef logic [6:0]  crc7_t;

    // Commands used by the identification sequence
    localparam cmd_idx_t CMD0   = 6'd0;
    localparam cmd_idx_t CMD2   = 6'd2;
    localparam cmd_idx_t CMD3   = 6'd3;
    localparam cmd_idx_t CMD8   = 6'd8;
    localparam cmd_idx_t CMD55  = 6'd55;
    localparam cmd_idx_t ACMD41 = 6'd41;

    typedef enum logic [2:0] {
        RESP_NONE,
        RESP_R1,
        RESP_R2,
        RESP_R3,
        RESP_R6,
        RESP_R7
    } resp_kind_e;

    typedef enum logic [1:0] {
        CMDERR_NONE,
        CMDERR_NO_RESPONSE,
        CMDERR_BAD_CRC,
        CMDERR_BAD_FRAME
    } cmd_err_e;

    // Short frame and R2 frame length in bits
    localparam int FRAME_BITS      = 48;
    localparam int LONG_FRAME_BITS = 136;

    typedef struct packed {
        cmd_idx_t   idx;
        cmd_arg_t   arg;
        resp_kind_e resp;
    } cmd_req_t;

    typedef struct packed {
        cmd_idx_t idx;
        cmd_arg_t data;
        cmd_err_e err;
    } cmd_resp_t;

endpackage
